//--- include/spiMaster_cfg.svh
`ifndef SPIMASTER_CFG_SVH
`define SPIMASTER_CFG_SVH

// ---------------------------------------------------------------------------
// Address map
// ---------------------------------------------------------------------------
// Address bits 15:8 that select the SPI block
`define SPI_BLOCK_BASE 8'h03

// Register offsets in address bits 7:0
`define SPI_REG_CTRL 8'h00
`define SPI_REG_DIV  8'h04
`define SPI_REG_TXD  8'h08
`define SPI_REG_CS   8'h0C
`define SPI_REG_RXD  8'h80

// ---------------------------------------------------------------------------
// Datapath sizes
// ---------------------------------------------------------------------------
// Clock divider register width
`define SPI_DIV_WIDTH 16
// One transfer, one byte
`define SPI_BITS 8

`endif

//--- source/spiPkg.sv
`include "spiMaster_cfg.svh"

package spiPkg;

	// ---------------------------------------------------------------------------
	// Wishbone classic
	// ---------------------------------------------------------------------------
	// Master to slave
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [15:0] adr;
		logic [31:0] dat;
	} wbReqT;

	// Slave to master
	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wbRspT;

	// ---------------------------------------------------------------------------
	// SPI side
	// ---------------------------------------------------------------------------
	// Software settings, fanned out from the register block
	typedef struct packed {
		logic                      start;
		logic [`SPI_DIV_WIDTH-1:0] div;
		logic [`SPI_BITS-1:0]      txByte;
		logic                      cs;
	} spiCfgT;

	// Output pins
	typedef struct packed {
		logic sclk;
		logic mosi;
		logic csN;
	} spiPinsT;

	// Transfer sequencer
	typedef enum logic [1:0] {
		IDLE,
		SHIFT,
		DONE
	} seqStateT;

endpackage

//--- source/spiCsr.sv
`timescale 1ns/1ps
`include "spiMaster_cfg.svh"

module spiCsr
(
	input  logic                 iSysClk,
	input  logic                 arstN,
	input  spiPkg::wbReqT        wbReq,
	output spiPkg::wbRspT        wbRsp,
	input  logic                 busy,
	input  logic [`SPI_BITS-1:0] rxData,
	output spiPkg::spiCfgT       cfg
);

	// ---------------------------------------------------------------------------
	// Bus decode
	// ---------------------------------------------------------------------------
	logic       blockHit;
	logic       accept;
	logic       wrEn;
	logic       rdEn;
	logic [7:0] offset;

	// Acknowledge and read data registers
	logic        ackQ;
	logic [31:0] rdQ;

	// Register file
	logic                      enable;
	logic [`SPI_DIV_WIDTH-1:0] divReg;
	logic [`SPI_BITS-1:0]      txReg;
	logic                      csReg;
	logic                      startQ;

	assign offset = wbReq.adr[7:0];
	// Upper address byte picks the block
	assign blockHit = (wbReq.adr[15:8] == `SPI_BLOCK_BASE);
	// No new accept in the ack cycle, stb is still high there
	assign accept = wbReq.cyc & wbReq.stb & blockHit & ~ackQ;
	assign wrEn = accept & wbReq.we;
	assign rdEn = accept & ~wbReq.we;

	// ---------------------------------------------------------------------------
	// Write side
	// ---------------------------------------------------------------------------
	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			ackQ   <= 1'b0;
			enable <= 1'b0;
			divReg <= '1;
			txReg  <= '0;
			csReg  <= 1'b1;
			startQ <= 1'b0;
		end
		else
		begin
			// One-cycle ack after the sampled request
			ackQ <= accept;
			// Start is a single pulse in the ack cycle
			startQ <= 1'b0;
			if (wrEn)
			begin
				case (offset)
					`SPI_REG_CTRL:
					begin
						enable <= wbReq.dat[0];
						// Dropped while a transfer runs
						startQ <= wbReq.dat[0] & ~busy;
					end
					`SPI_REG_DIV:  divReg <= wbReq.dat[`SPI_DIV_WIDTH-1:0];
					`SPI_REG_TXD:  txReg <= wbReq.dat[`SPI_BITS-1:0];
					`SPI_REG_CS:   csReg <= wbReq.dat[0];
					default:       ;
				endcase
			end
		end
	end

	// ---------------------------------------------------------------------------
	// Read side
	// ---------------------------------------------------------------------------
	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
			rdQ <= '0;
		else if (rdEn)
		begin
			case (offset)
				// Bit 1 reports a running transfer
				`SPI_REG_CTRL: rdQ <= {30'd0, busy, enable};
				`SPI_REG_DIV:  rdQ <= {{(32 - `SPI_DIV_WIDTH){1'b0}}, divReg};
				`SPI_REG_TXD:  rdQ <= {{(32 - `SPI_BITS){1'b0}}, txReg};
				`SPI_REG_CS:   rdQ <= {31'd0, csReg};
				`SPI_REG_RXD:  rdQ <= {{(32 - `SPI_BITS){1'b0}}, rxData};
				// Hole in the map
				default:       rdQ <= '0;
			endcase
		end
		else
			rdQ <= '0;
	end

	assign wbRsp.ack = ackQ;
	assign wbRsp.dat = rdQ;

	// Settings out to the datapath
	assign cfg.start  = startQ;
	assign cfg.div    = divReg;
	assign cfg.txByte = txReg;
	assign cfg.cs     = csReg;

	// Master drops stb after ack, so acks stay isolated
	ackSingle: assert property (@(posedge iSysClk) disable iff (!arstN)
		wbRsp.ack |=> !wbRsp.ack);

endmodule

//--- source/spiClkTimer.sv
`timescale 1ns/1ps
`include "spiMaster_cfg.svh"

module spiClkTimer
(
	input  logic                      iSysClk,
	input  logic                      arstN,
	input  logic                      run,
	input  logic [`SPI_DIV_WIDTH-1:0] div,
	output logic                      tick
);

	// Half-period down-counter
	logic [`SPI_DIV_WIDTH-1:0] cnt;

	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
			cnt <= '1;
		// Parked at the divider while idle
		else if (!run)
			cnt <= div;
		// div+1 clocks per half period
		else if (cnt == '0)
			cnt <= div;
		else
			cnt <= cnt - 1'b1;
	end

	// Tick on the last clock of each half period
	assign tick = run & (cnt == '0);

	// A stopped timer stays quiet, so no stray sclk edges
	tickOnlyRun: assert property (@(posedge iSysClk) disable iff (!arstN)
		!run |-> !tick);

endmodule

//--- source/spiSequencer.sv
`timescale 1ns/1ps
`include "spiMaster_cfg.svh"

module spiSequencer
(
	input  logic iSysClk,
	input  logic arstN,
	input  logic start,
	input  logic tick,
	output logic run,
	output logic load,
	output logic sclk,
	output logic sampleEn,
	output logic shiftEn,
	output logic busy
);

	// Enough room for 2*SPI_BITS edges
	localparam int EdgeW = $clog2(2 * `SPI_BITS + 1);

	spiPkg::seqStateT state;
	logic [EdgeW-1:0] edgeCnt;
	logic             lastEdge;
	logic             sclkQ;

	// Final falling edge of the byte
	assign lastEdge = (edgeCnt == EdgeW'(2 * `SPI_BITS - 1));

	// ---------------------------------------------------------------------------
	// State and edge counter
	// ---------------------------------------------------------------------------
	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			state   <= spiPkg::IDLE;
			edgeCnt <= '0;
			sclkQ   <= 1'b0;
		end
		else
		begin
			case (state)
				spiPkg::IDLE:
				begin
					if (start)
					begin
						state   <= spiPkg::SHIFT;
						edgeCnt <= '0;
						sclkQ   <= 1'b0;
					end
				end
				spiPkg::SHIFT:
				begin
					if (tick)
					begin
						// Every tick is one sclk edge
						sclkQ   <= ~sclkQ;
						edgeCnt <= edgeCnt + 1'b1;
						if (lastEdge)
							state <= spiPkg::DONE;
					end
				end
				// One idle cycle, receive byte lands here
				spiPkg::DONE:
					state <= spiPkg::IDLE;
				default:
					state <= spiPkg::IDLE;
			endcase
		end
	end

	// ---------------------------------------------------------------------------
	// Controls
	// ---------------------------------------------------------------------------
	assign run  = (state == spiPkg::SHIFT);
	assign busy = run;
	// Shifter takes the byte on the edge busy rises
	assign load = start & (state == spiPkg::IDLE);
	assign sclk = sclkQ;
	// Rising sclk samples, falling sclk shifts
	assign sampleEn = tick & run & ~sclkQ;
	assign shiftEn  = tick & run & sclkQ;

	// Only a start pulse leaves IDLE
	idleHold: assert property (@(posedge iSysClk) disable iff (!arstN)
		(state == spiPkg::IDLE) && !start |=> (state == spiPkg::IDLE));

endmodule

//--- source/spiShifter.sv
`timescale 1ns/1ps
`include "spiMaster_cfg.svh"

module spiShifter
(
	input  logic                 iSysClk,
	input  logic                 arstN,
	input  logic                 load,
	input  logic [`SPI_BITS-1:0] txData,
	input  logic                 sampleEn,
	input  logic                 shiftEn,
	input  logic                 done,
	input  logic                 miso,
	output logic                 mosi,
	output logic [`SPI_BITS-1:0] rxData
);

	// One register for both directions
	logic [`SPI_BITS-1:0] shiftReg;
	logic                 misoBit;
	logic                 doneQ;
	logic                 doneFall;

	// Busy from the sequencer, end of transfer on its fall
	assign doneFall = doneQ & ~done;

	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			shiftReg <= '0;
			misoBit  <= 1'b0;
			doneQ    <= 1'b0;
			rxData   <= '0;
		end
		else
		begin
			doneQ <= done;
			if (load)
				shiftReg <= txData;
			// Received bit enters at the bottom on the falling edge
			else if (shiftEn)
				shiftReg <= {shiftReg[`SPI_BITS-2:0], misoBit};
			// Capture on rising sclk
			if (sampleEn)
				misoBit <= miso;
			// All bits in after the last shift
			if (doneFall)
				rxData <= shiftReg;
		end
	end

	// MSB first
	assign mosi = shiftReg[`SPI_BITS-1];

endmodule

//--- source/spiMasterTop.sv
`timescale 1ns/1ps
`include "spiMaster_cfg.svh"

module spiMasterTop
(
	input  logic           iSysClk,
	input  logic           arstN,
	input  spiPkg::wbReqT  wbReq,
	output spiPkg::wbRspT  wbRsp,
	input  logic           miso,
	output spiPkg::spiPinsT spiPins
);

	// ---------------------------------------------------------------------------
	// Internal nets
	// ---------------------------------------------------------------------------
	spiPkg::spiCfgT       cfg;
	logic                 busy;
	logic [`SPI_BITS-1:0] rxData;
	logic                 run;
	logic                 tick;
	logic                 load;
	logic                 sclk;
	logic                 sampleEn;
	logic                 shiftEn;
	logic                 mosi;

	// Processor registers
	spiCsr uCsr
	(
		.iSysClk (iSysClk),
		.arstN   (arstN),
		.wbReq   (wbReq),
		.wbRsp   (wbRsp),
		.busy    (busy),
		.rxData  (rxData),
		.cfg     (cfg)
	);

	// Half-period tick
	spiClkTimer uClkTimer
	(
		.iSysClk (iSysClk),
		.arstN   (arstN),
		.run     (run),
		.div     (cfg.div),
		.tick    (tick)
	);

	// Edge sequencing
	spiSequencer uSequencer
	(
		.iSysClk  (iSysClk),
		.arstN    (arstN),
		.start    (cfg.start),
		.tick     (tick),
		.run      (run),
		.load     (load),
		.sclk     (sclk),
		.sampleEn (sampleEn),
		.shiftEn  (shiftEn),
		.busy     (busy)
	);

	// Data shifting, done follows busy
	spiShifter uShifter
	(
		.iSysClk  (iSysClk),
		.arstN    (arstN),
		.load     (load),
		.txData   (cfg.txByte),
		.sampleEn (sampleEn),
		.shiftEn  (shiftEn),
		.done     (busy),
		.miso     (miso),
		.mosi     (mosi),
		.rxData   (rxData)
	);

	// Chip select is the software register bit
	assign spiPins.sclk = sclk;
	assign spiPins.mosi = mosi;
	assign spiPins.csN  = cfg.cs;

endmodule

//--- bench/spiChecker.sv
`timescale 1ns/1ps
`include "spiMaster_cfg.svh"

module spiChecker
(
	input  logic            iSysClk,
	input  logic            arstN,
	input  spiPkg::wbReqT   wbReq,
	input  spiPkg::wbRspT   wbRsp,
	input  spiPkg::spiPinsT spiPins,
	input  logic            miso,
	output int              errCount,
	output int              checkCount,
	output logic            xferOpen
);

	// Register model, fed from acknowledged writes
	logic                      enableM;
	logic [`SPI_DIV_WIDTH-1:0] divM;
	logic [`SPI_BITS-1:0]      txdM;
	logic                      csM;
	logic [`SPI_BITS-1:0]      rxdM;
	logic [31:0]               gotRd;

	// Expected busy, clocks still to run and the last two cycles
	int                        busyLeft;
	logic [1:0]                busyHist;

	// Transfer tracking from the pins
	int                        edgeCnt;
	int                        phaseLen;
	logic                      sclkLast;
	logic [`SPI_DIV_WIDTH-1:0] xferDiv;
	logic [`SPI_BITS-1:0]      xferTx;
	logic [`SPI_BITS-1:0]      mosiSeen;
	logic [`SPI_BITS-1:0]      misoSeen;

	// Expected read data for one offset
	function automatic logic [31:0] expectedRead(input logic [7:0] offset);
		case (offset)
			// Busy as it was when the read was accepted
			`SPI_REG_CTRL: return {30'd0, busyHist[1], enableM};
			`SPI_REG_DIV:  return {{(32 - `SPI_DIV_WIDTH){1'b0}}, divM};
			`SPI_REG_TXD:  return {{(32 - `SPI_BITS){1'b0}}, txdM};
			`SPI_REG_CS:   return {31'd0, csM};
			`SPI_REG_RXD:  return {{(32 - `SPI_BITS){1'b0}}, rxdM};
			// Holes read as zero
			default:       return 32'd0;
		endcase
	endfunction

	task automatic flagError(input string msg);
		$display("error %0t ns: %s", $time, msg);
		errCount++;
	endtask

	// Values seen here were stable through the cycle before this edge
	always @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			enableM    = 1'b0;
			divM       = '1;
			txdM       = '0;
			csM        = 1'b1;
			rxdM       = '0;
			busyLeft   = 0;
			busyHist   = '0;
			xferOpen   = 1'b0;
			edgeCnt    = 0;
			phaseLen   = 0;
			sclkLast   = 1'b0;
			errCount   = 0;
			checkCount = 0;
		end
		else
		begin
			// Busy of the cycle that just ended
			busyHist = {busyHist[0], busyLeft > 0};
			if (busyLeft > 0)
				busyLeft--;

			// ---------------------------------------------------------------------------
			// Bus side
			// ---------------------------------------------------------------------------
			if (wbRsp.ack)
			begin
				if (wbReq.adr[15:8] != `SPI_BLOCK_BASE)
					flagError("acknowledge for an address outside the block");
				else if (wbReq.we)
				begin
					case (wbReq.adr[7:0])
						`SPI_REG_CTRL:
						begin
							enableM = wbReq.dat[0];
							// Start counts only if busy was low at the accept
							if (wbReq.dat[0] && !busyHist[1])
							begin
								if (xferOpen)
									flagError($sformatf("new start after only %0d sclk edges",
										edgeCnt));
								xferOpen = 1'b1;
								edgeCnt  = 0;
								xferDiv  = divM;
								xferTx   = txdM;
								// Busy spans every sclk phase of the byte
								busyLeft = 2 * `SPI_BITS * (int'(divM) + 1);
							end
						end
						`SPI_REG_DIV: divM = wbReq.dat[`SPI_DIV_WIDTH-1:0];
						`SPI_REG_TXD: txdM = wbReq.dat[`SPI_BITS-1:0];
						`SPI_REG_CS:  csM = wbReq.dat[0];
						default:      ;
					endcase
				end
				else
				begin
					checkCount++;
					gotRd = wbRsp.dat;
					if (gotRd != expectedRead(wbReq.adr[7:0]))
						flagError($sformatf("read offset %h gave %h, expected %h",
							wbReq.adr[7:0], wbRsp.dat, expectedRead(wbReq.adr[7:0])));
				end
			end

			// ---------------------------------------------------------------------------
			// Pin side
			// ---------------------------------------------------------------------------
			if (spiPins.sclk != sclkLast)
			begin
				if (!xferOpen)
					flagError("sclk edge outside a transfer");
				else
				begin
					checkCount++;
					// First rise follows an idle low, no phase to measure
					if (edgeCnt > 0 && phaseLen != int'(xferDiv) + 1)
						flagError($sformatf("sclk phase of %0d clocks, expected %0d",
							phaseLen, int'(xferDiv) + 1));
					if (spiPins.csN != csM)
						flagError("csN differs from the CS register");
					// Mode 0, both lines valid at the rise
					if (spiPins.sclk)
					begin
						mosiSeen = {mosiSeen[`SPI_BITS-2:0], spiPins.mosi};
						misoSeen = {misoSeen[`SPI_BITS-2:0], miso};
					end
					edgeCnt++;
					if (edgeCnt == 2 * `SPI_BITS)
					begin
						if (mosiSeen != xferTx)
							flagError($sformatf("mosi sent %h, expected %h", mosiSeen, xferTx));
						// RXD now owes what the slave drove
						rxdM     = misoSeen;
						xferOpen = 1'b0;
					end
				end
				phaseLen = 1;
			end
			else
				phaseLen++;
			sclkLast = spiPins.sclk;
		end
	end

endmodule

//--- bench/spiTb.sv
`timescale 1ns/1ps
`include "spiMaster_cfg.svh"

module spiTb;

	localparam int AckLimit  = 50;
	localparam int PollLimit = 100;
	localparam int XferCount = 6;

	logic            iSysClk;
	logic            arstN;
	spiPkg::wbReqT   wbReq;
	spiPkg::wbRspT   wbRsp;
	spiPkg::spiPinsT spiPins;
	logic            miso;

	int          errCount;
	int          checkCount;
	logic        xferOpen;
	int          stallCount;
	logic [16:0] lfsrState;

	// Slave model state
	logic [7:0] replyByte = '0;
	int         sclkFalls = 0;
	int         csFallMark = 0;
	int         slaveIdx;

	spiMasterTop DUT
	(
		.iSysClk (iSysClk),
		.arstN   (arstN),
		.wbReq   (wbReq),
		.wbRsp   (wbRsp),
		.miso    (miso),
		.spiPins (spiPins)
	);

	spiChecker uChecker
	(
		.iSysClk    (iSysClk),
		.arstN      (arstN),
		.wbReq      (wbReq),
		.wbRsp      (wbRsp),
		.spiPins    (spiPins),
		.miso       (miso),
		.errCount   (errCount),
		.checkCount (checkCount),
		.xferOpen   (xferOpen)
	);

	initial
	begin
		iSysClk = 1'b0;
		forever #2 iSysClk = ~iSysClk;
	end

	// ---------------------------------------------------------------------------
	// SPI slave, MSB first, next bit after each sclk fall
	// ---------------------------------------------------------------------------
	always @(negedge spiPins.sclk)
		sclkFalls++;
	// Chip select fall restarts at the top bit
	always @(negedge spiPins.csN)
		csFallMark = sclkFalls;
	assign slaveIdx = sclkFalls - csFallMark;
	assign miso = (slaveIdx < `SPI_BITS) ? replyByte[`SPI_BITS - 1 - slaveIdx] : 1'b0;

	// Fibonacci LFSR, taps 17 and 14
	function automatic logic [16:0] lfsrNext(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	// One LFSR step per bit
	task automatic drawBits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			v = {v[14:0], lfsrState[0]};
		end
	endtask

	// ---------------------------------------------------------------------------
	// Wishbone classic master
	// ---------------------------------------------------------------------------
	task automatic busWrite(input logic [7:0] offset, input logic [31:0] dat);
		int n;
		logic seen;
		@(negedge iSysClk);
		wbReq.cyc = 1'b1;
		wbReq.stb = 1'b1;
		wbReq.we  = 1'b1;
		wbReq.adr = {`SPI_BLOCK_BASE, offset};
		wbReq.dat = dat;
		seen = 1'b0;
		n = 0;
		while (!seen && n < AckLimit)
		begin
			@(negedge iSysClk);
			n++;
			seen = wbRsp.ack;
		end
		// Hold through the ack cycle, then drop the request
		if (seen)
			@(negedge iSysClk);
		wbReq = '0;
		if (!seen)
		begin
			$display("No acknowledge for a write to offset %h", offset);
			stallCount++;
		end
	endtask

	task automatic busRead(input logic [7:0] offset, output logic [31:0] dat);
		int n;
		logic seen;
		@(negedge iSysClk);
		wbReq.cyc = 1'b1;
		wbReq.stb = 1'b1;
		wbReq.we  = 1'b0;
		wbReq.adr = {`SPI_BLOCK_BASE, offset};
		wbReq.dat = '0;
		seen = 1'b0;
		dat = '0;
		n = 0;
		while (!seen && n < AckLimit)
		begin
			@(negedge iSysClk);
			n++;
			seen = wbRsp.ack;
			if (seen)
				dat = wbRsp.dat;
		end
		if (seen)
			@(negedge iSysClk);
		wbReq = '0;
		if (!seen)
		begin
			$display("No acknowledge for a read of offset %h", offset);
			stallCount++;
		end
	endtask

	// Write to another block, held long past the one-clock ack latency
	task automatic busWriteOutside(input logic [15:0] adr, input logic [31:0] dat);
		@(negedge iSysClk);
		wbReq.cyc = 1'b1;
		wbReq.stb = 1'b1;
		wbReq.we  = 1'b1;
		wbReq.adr = adr;
		wbReq.dat = dat;
		repeat (4) @(negedge iSysClk);
		wbReq = '0;
	endtask

	// Software view of the end of a transfer
	task automatic pollIdle();
		int n;
		logic [31:0] v;
		v = 32'h2;
		n = 0;
		while (v[1] && n < PollLimit)
		begin
			busRead(`SPI_REG_CTRL, v);
			n++;
		end
		if (v[1])
		begin
			$display("Busy never cleared after a start");
			stallCount++;
		end
	endtask

	task automatic runTransfer(input logic [15:0] div, input logic [7:0] tx,
		input logic [7:0] reply, input logic twice);
		logic [31:0] v;
		busWrite(`SPI_REG_DIV, {16'd0, div});
		busWrite(`SPI_REG_TXD, {24'd0, tx});
		replyByte = reply;
		busWrite(`SPI_REG_CS, 32'd0);
		busWrite(`SPI_REG_CTRL, 32'd1);
		// Lands while busy, must be dropped
		if (twice)
			busWrite(`SPI_REG_CTRL, 32'd1);
		pollIdle();
		busRead(`SPI_REG_RXD, v);
		busWrite(`SPI_REG_CS, 32'd1);
	endtask

	task automatic finishRun();
		if (xferOpen)
		begin
			$display("A transfer was still open when the stimulus ended");
			stallCount++;
		end
		$display("Summary: %0d checks, %0d errors, %0d stalls", checkCount, errCount, stallCount);
		if (errCount == 0 && stallCount == 0 && checkCount > 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	endtask

	// ---------------------------------------------------------------------------
	// Stimulus
	// ---------------------------------------------------------------------------
	initial
	begin : stimulus
		logic [15:0] r;
		logic [15:0] tx;
		logic [15:0] rep;
		logic [31:0] v;
		arstN = 1'b0;
		wbReq = '0;
		stallCount = 0;
		lfsrState = 17'd73691;
		repeat (3) @(posedge iSysClk);
		@(negedge iSysClk);
		arstN = 1'b1;
		// Reset values
		busRead(`SPI_REG_CTRL, v);
		busRead(`SPI_REG_DIV, v);
		busRead(`SPI_REG_TXD, v);
		busRead(`SPI_REG_CS, v);
		busRead(`SPI_REG_RXD, v);
		// Other block, no ack and DIV untouched
		busWriteOutside({`SPI_BLOCK_BASE ^ 8'h01, `SPI_REG_DIV}, 32'h0000_1234);
		busRead(`SPI_REG_DIV, v);
		// Write and read back
		drawBits(16, r);
		busWrite(`SPI_REG_DIV, {16'd0, r});
		busRead(`SPI_REG_DIV, v);
		drawBits(8, r);
		busWrite(`SPI_REG_TXD, {16'd0, r});
		busRead(`SPI_REG_TXD, v);
		busWrite(`SPI_REG_CS, 32'd0);
		busRead(`SPI_REG_CS, v);
		busWrite(`SPI_REG_CS, 32'd1);
		busRead(`SPI_REG_CS, v);
		// Unmapped offset in the block
		busRead(8'h40, v);
		// Transfers, the third one gets a second start
		for (int t = 0; t < XferCount; t++)
		begin
			drawBits(3, r);
			drawBits(8, tx);
			drawBits(8, rep);
			runTransfer(r % 16'd6, tx[7:0], rep[7:0], t == 2);
		end
		finishRun();
	end

endmodule

//--- sources.f
+incdir+include
source/spiPkg.sv
source/spiCsr.sv
source/spiClkTimer.sv
source/spiSequencer.sv
source/spiShifter.sv
source/spiMasterTop.sv
bench/spiChecker.sv
bench/spiTb.sv

//--- runSim.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module spiTb -f sources.f \
	-o spiSim > build.log 2>&1 &&
	./obj_dir/spiSim > sim.log 2>&1 ||
	echo "Build or simulation failed, see build.log and sim.log"
grep -qx "TB PASSED" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
